/* Bender.yml */
package:
  name: cpu_core

sources:
  - hw/isa_pkg.sv
  - hw/core_pkg.sv
  - hw/ctrl_if.sv
  - hw/control_decoder.sv
  - hw/reg_file.sv
  - hw/alu.sv
  - hw/fetch_unit.sv
  - hw/cpu_core.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/cpu_checker.sv
      - tests/cpu_tb.sv

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
(
    ctrl_if.exec                 ctrl,
    input  wire core_pkg::word_t op_a,
    input  wire core_pkg::word_t op_b,
    output core_pkg::word_t      result,
    output logic                 zero
);

    core_pkg::word_t operand_b;

    // immediate wins over negation, loadi never negates
    assign operand_b = ctrl.use_imm  ? ctrl.imm
                     : ctrl.negate_b ? ~op_b + 1'b1
                     : op_b;

    always_comb
    begin
        case (ctrl.alu_op)
            core_pkg::FWD: result = operand_b;
            core_pkg::ADD: result = op_a + operand_b;    // wraps at 8 bits
            core_pkg::AND: result = op_a & operand_b;
            core_pkg::OR:  result = op_a | operand_b;
            default:       result = operand_b;
        endcase
    end

    assign zero = (result == '0);    // branch compare outcome

endmodule

`default_nettype wire

/* hw/control_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module control_decoder
(
    input  wire [isa_pkg::INSTR_W-1:0] instruction,
    ctrl_if.decoder                    ctrl
);

    isa_pkg::opcode_e opcode;

    assign opcode = isa_pkg::opcode_e'(instruction[isa_pkg::OPC_LSB +: isa_pkg::OPC_W]);

    // field split, immediate and offset overlap the register fields
    assign ctrl.rd     = instruction[isa_pkg::RD_LSB  +: $bits(core_pkg::reg_idx_t)];
    assign ctrl.rs1    = instruction[isa_pkg::RS1_LSB +: $bits(core_pkg::reg_idx_t)];
    assign ctrl.rs2    = instruction[isa_pkg::RS2_LSB +: $bits(core_pkg::reg_idx_t)];
    assign ctrl.imm    = instruction[isa_pkg::IMM_LSB +: isa_pkg::IMM_W];
    assign ctrl.offset = instruction[isa_pkg::OFS_LSB +: isa_pkg::OFS_W];

    always_comb
    begin
        ctrl.alu_op    = core_pkg::FWD;    // everything off unless set below
        ctrl.negate_b  = 1'b0;
        ctrl.use_imm   = 1'b0;
        ctrl.reg_write = 1'b0;
        ctrl.branch_eq = 1'b0;
        ctrl.branch_ne = 1'b0;
        ctrl.jump      = 1'b0;

        case (opcode)
            isa_pkg::OPC_LOADI:
            begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::OPC_MOV:
            begin
                ctrl.reg_write = 1'b1;    // forwards rs2
            end
            isa_pkg::OPC_ADD:
            begin
                ctrl.alu_op    = core_pkg::ADD;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::OPC_SUB:
            begin
                ctrl.alu_op    = core_pkg::ADD;
                ctrl.negate_b  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::OPC_AND:
            begin
                ctrl.alu_op    = core_pkg::AND;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::OPC_OR:
            begin
                ctrl.alu_op    = core_pkg::OR;
                ctrl.reg_write = 1'b1;
            end
            isa_pkg::OPC_J:
            begin
                ctrl.jump = 1'b1;
            end
            isa_pkg::OPC_BEQ:
            begin
                ctrl.alu_op    = core_pkg::ADD;    // rs1 - rs2 feeds zero flag
                ctrl.negate_b  = 1'b1;
                ctrl.branch_eq = 1'b1;
            end
            isa_pkg::OPC_BNE:
            begin
                ctrl.alu_op    = core_pkg::ADD;
                ctrl.negate_b  = 1'b1;
                ctrl.branch_ne = 1'b1;
            end
            default:
            begin
                ctrl.reg_write = 1'b0;    // unused opcode retires as a no-op
            end
        endcase
    end

    // sampled on every instruction change, so each word's bundle gets checked
    assert property (@(instruction) $onehot0({ctrl.branch_eq, ctrl.branch_ne, ctrl.jump}))
        else $error("decoder asserted more than one of beq, bne and j");

endmodule

`default_nettype wire

/* hw/core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN     = 8;
    localparam int NUM_REGS = 8;
    localparam int ADDR_W   = 32;

    typedef logic [XLEN-1:0]             word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
    typedef logic [ADDR_W-1:0]           addr_t;    // byte address

    localparam addr_t PC_STEP = 32'd4;               // one instruction word

    typedef enum logic [2:0] {
        FWD = 3'd0,    // pass second operand through
        ADD = 3'd1,
        AND = 3'd2,
        OR  = 3'd3
    } alu_op_e;

endpackage

`default_nettype wire

/* hw/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core
(
    input  wire                        CLK,
    input  wire                        RESET,
    output core_pkg::addr_t            fetch_addr,
    input  wire [isa_pkg::INSTR_W-1:0] instruction,
    output logic                       retire_valid,
    output core_pkg::addr_t            retire_pc,
    output logic                       wb_en,
    output core_pkg::reg_idx_t         wb_addr,
    output core_pkg::word_t            wb_data
);

    ctrl_if ctrl ();

    core_pkg::word_t rdata1;
    core_pkg::word_t rdata2;
    core_pkg::word_t alu_result;
    logic            zero;
    logic            write_en;

    assign write_en = ctrl.reg_write & retire_valid;    // no write from a squashed slot

    // writeback taps the register file write port
    assign wb_en   = write_en;
    assign wb_addr = ctrl.rd;
    assign wb_data = alu_result;

    control_decoder u_decoder (
        .instruction (instruction),
        .ctrl        (ctrl.decoder)
    );

    reg_file u_reg_file (
        .CLK        (CLK),
        .RESET      (RESET),
        .ctrl       (ctrl.exec),
        .write_en   (write_en),
        .write_data (alu_result),
        .rdata1     (rdata1),
        .rdata2     (rdata2)
    );

    alu u_alu (
        .ctrl   (ctrl.exec),
        .op_a   (rdata1),
        .op_b   (rdata2),
        .result (alu_result),
        .zero   (zero)
    );

    fetch_unit u_fetch (
        .CLK        (CLK),
        .RESET      (RESET),
        .ctrl       (ctrl.exec),
        .zero       (zero),
        .fetch_addr (fetch_addr),
        .exec_pc    (retire_pc),
        .exec_valid (retire_valid)
    );

endmodule

`default_nettype wire

/* hw/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;

    core_pkg::alu_op_e  alu_op;
    logic               negate_b;   // sub and both branches
    logic               use_imm;    // loadi
    logic               reg_write;
    logic               branch_eq;
    logic               branch_ne;
    logic               jump;
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::word_t    imm;
    core_pkg::word_t    offset;     // signed word offset

    modport decoder (
        output alu_op, negate_b, use_imm, reg_write,
        output branch_eq, branch_ne, jump,
        output rd, rs1, rs2, imm, offset
    );

    modport exec (
        input alu_op, negate_b, use_imm, reg_write,
        input branch_eq, branch_ne, jump,
        input rd, rs1, rs2, imm, offset
    );

endinterface

`default_nettype wire

/* hw/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
(
    input  wire           CLK,
    input  wire           RESET,
    ctrl_if.exec          ctrl,
    input  wire           zero,
    output core_pkg::addr_t fetch_addr,
    output core_pkg::addr_t exec_pc,
    output logic          exec_valid
);

    logic            taken;
    core_pkg::addr_t offset_words;
    core_pkg::addr_t target;

    // squashed slot carries a stale bundle
    assign taken = exec_valid & (ctrl.jump
                               | (ctrl.branch_eq & zero)
                               | (ctrl.branch_ne & ~zero));

    assign offset_words = {{(core_pkg::ADDR_W - isa_pkg::OFS_W){ctrl.offset[isa_pkg::OFS_W-1]}},
                           ctrl.offset[isa_pkg::OFS_W-1:0]};

    // relative to the address after the executing instruction
    assign target = exec_pc + core_pkg::PC_STEP + offset_words * core_pkg::PC_STEP;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            fetch_addr <= '0;
            exec_valid <= 1'b0;
        end
        else
        begin
            fetch_addr <= taken ? target : fetch_addr + core_pkg::PC_STEP;
            exec_valid <= ~taken;    // word already in flight is wrong path
        end
    end

    // instruction memory samples fetch_addr at this same edge
    always_ff @(posedge CLK)
    begin
        exec_pc <= fetch_addr;
    end

    assert property (@(posedge CLK) disable iff (RESET) fetch_addr[1:0] == 2'b00)
        else $error("fetch address 0x%08h not word aligned", fetch_addr);

endmodule

`default_nettype wire

/* hw/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int INSTR_W = 32;
    localparam int OPC_W   = 8;
    localparam int IMM_W   = 8;
    localparam int OFS_W   = 8;    // signed, counted in instruction words

    // lowest bit of each field in the instruction word
    localparam int OPC_LSB = 24;
    localparam int RD_LSB  = 16;
    localparam int RS1_LSB = 8;
    localparam int RS2_LSB = 0;
    localparam int IMM_LSB = 0;    // same bits as rs2
    localparam int OFS_LSB = 16;   // same bits as rd

    // opcodes this core executes; any other value is a no-op
    typedef enum logic [OPC_W-1:0] {
        OPC_LOADI = 8'd0,
        OPC_MOV   = 8'd1,
        OPC_ADD   = 8'd2,
        OPC_SUB   = 8'd3,
        OPC_AND   = 8'd4,
        OPC_OR    = 8'd5,
        OPC_J     = 8'd6,
        OPC_BEQ   = 8'd7,
        OPC_BNE   = 8'd12
    } opcode_e;

endpackage

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file
(
    input  wire                  CLK,
    input  wire                  RESET,
    ctrl_if.exec                 ctrl,
    input  wire                  write_en,
    input  wire core_pkg::word_t write_data,
    output core_pkg::word_t      rdata1,
    output core_pkg::word_t      rdata2
);

    core_pkg::word_t regs [core_pkg::NUM_REGS];

    // combinational reads, a write shows up after the edge
    assign rdata1 = regs[ctrl.rs1];
    assign rdata2 = regs[ctrl.rs2];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < core_pkg::NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (write_en)
        begin
            regs[ctrl.rd] <= write_data;
        end
    end

    // rd comes from the decoder through the bundle, write_en from the top
    assert property (@(posedge CLK) disable iff (RESET) write_en |-> !$isunknown(ctrl.rd))
        else $error("register write with unknown destination index");

endmodule

`default_nettype wire

/* tests/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker
(
    input  wire                     CLK,
    input  wire                     RESET,
    input  wire core_pkg::addr_t    fetch_addr,
    input  wire                     retire_valid,
    input  wire core_pkg::addr_t    retire_pc,
    input  wire                     wb_en,
    input  wire core_pkg::reg_idx_t wb_addr,
    input  wire core_pkg::word_t    wb_data,
    output core_pkg::addr_t         model_pc,
    input  wire [31:0]              model_word,
    output int                      retire_count,
    output int                      mismatch_count,
    output int                      error_count
);

    typedef struct packed {
        logic               wr_en;
        core_pkg::reg_idx_t wr_addr;
        core_pkg::word_t    wr_data;
        logic               taken;
        core_pkg::addr_t    next_pc;
    } outcome_t;

    core_pkg::word_t model_regs [8];
    logic            expect_bubble;    // slot after a taken branch or jump
    int              reset_edges;
    outcome_t        expected;

    // effect of one instruction at pc on the model state
    function automatic outcome_t predict(input logic [31:0] word, input core_pkg::addr_t pc);
        logic [7:0]      opc;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::addr_t ofs;
        outcome_t        res;
        opc         = word[31:24];
        a           = model_regs[word[10:8]];
        b           = model_regs[word[2:0]];
        ofs         = {{24{word[23]}}, word[23:16]};    // signed word count
        res.wr_en   = 1'b1;
        res.wr_addr = word[18:16];
        res.wr_data = '0;
        res.taken   = 1'b0;
        case (opc)
            isa_pkg::OPC_LOADI: res.wr_data = word[7:0];
            isa_pkg::OPC_MOV:   res.wr_data = b;
            isa_pkg::OPC_ADD:   res.wr_data = a + b;
            isa_pkg::OPC_SUB:   res.wr_data = a - b;
            isa_pkg::OPC_AND:   res.wr_data = a & b;
            isa_pkg::OPC_OR:    res.wr_data = a | b;
            default:
            begin
                res.wr_en = 1'b0;    // j, branches and unused opcodes
                res.taken = (opc == isa_pkg::OPC_J)
                          || (opc == isa_pkg::OPC_BEQ && a == b)
                          || (opc == isa_pkg::OPC_BNE && a != b);
            end
        endcase
        res.next_pc = res.taken ? pc + 32'd4 + (ofs << 2) : pc + 32'd4;
        return res;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("MISMATCH @%0t: %s", $time, msg);
        mismatch_count++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR @%0t: %s", $time, msg);
        error_count++;
    endtask

    initial
    begin
        retire_count   = 0;
        mismatch_count = 0;
        error_count    = 0;
        reset_edges    = 0;
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            // outputs are only defined once the first reset edge has passed
            if (reset_edges != 0 && (retire_valid !== 1'b0 || wb_en !== 1'b0
                                     || fetch_addr !== '0))
            begin
                report_mismatch("core outputs not cleared during reset");
            end
            for (int i = 0; i < 8; i++)
            begin
                model_regs[i] <= '0;
            end
            model_pc      <= '0;
            expect_bubble <= 1'b1;    // first cycle after reset is empty
            reset_edges   <= reset_edges + 1;
        end
        else if (expect_bubble)
        begin
            if (retire_valid !== 1'b0 || wb_en !== 1'b0)
            begin
                report_error("an instruction retired in a slot that should be empty");
            end
            if (fetch_addr !== model_pc)
            begin
                report_mismatch($sformatf("fetch_addr %h, expected %h", fetch_addr, model_pc));
            end
            expect_bubble <= 1'b0;
        end
        else if (retire_valid !== 1'b1)
        begin
            report_error("no instruction retired in a slot that should be full");
        end
        else
        begin
            expected = predict(model_word, model_pc);
            retire_count <= retire_count + 1;
            if (retire_pc !== model_pc)
            begin
                report_mismatch($sformatf("retire_pc %h, expected %h", retire_pc, model_pc));
            end
            if (wb_en !== expected.wr_en)
            begin
                report_mismatch($sformatf("pc %h wb_en %b, expected %b",
                                          model_pc, wb_en, expected.wr_en));
            end
            else if (expected.wr_en && (wb_addr !== expected.wr_addr
                                        || wb_data !== expected.wr_data))
            begin
                report_mismatch($sformatf("pc %h wrote r%0d=%h, expected r%0d=%h", model_pc,
                                          wb_addr, wb_data, expected.wr_addr, expected.wr_data));
            end
            if (expected.wr_en)
            begin
                model_regs[expected.wr_addr] <= expected.wr_data;
            end
            model_pc      <= expected.next_pc;
            expect_bubble <= expected.taken;
        end
    end

endmodule

`default_nettype wire

/* tests/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int          MEM_WORDS  = 256;
    localparam int          NUM_RANDOM = 48;
    localparam int          TIMEOUT    = 2000;    // cycles allowed per wait
    localparam logic [31:0] SEED       = 32'h386e62da;

    logic               CLK;
    logic               RESET;
    logic [31:0]        instruction = '0;
    core_pkg::addr_t    fetch_addr;
    logic               retire_valid;
    core_pkg::addr_t    retire_pc;
    logic               wb_en;
    core_pkg::reg_idx_t wb_addr;
    core_pkg::word_t    wb_data;
    core_pkg::addr_t    model_pc;
    logic [31:0]        model_word;
    int                 retire_count;
    int                 mismatch_count;
    int                 error_count;
    int                 timeouts;
    int                 prog_len;
    int                 exec_total;    // words of the program that actually run
    logic [31:0]        imem [MEM_WORDS];

    tb_clock_gen u_clock_gen (
        .CLK   (CLK),
        .RESET (RESET)
    );

    cpu_core UUT (
        .CLK          (CLK),
        .RESET        (RESET),
        .fetch_addr   (fetch_addr),
        .instruction  (instruction),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .wb_en        (wb_en),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data)
    );

    cpu_checker u_checker (
        .CLK            (CLK),
        .RESET          (RESET),
        .fetch_addr     (fetch_addr),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .model_pc       (model_pc),
        .model_word     (model_word),
        .retire_count   (retire_count),
        .mismatch_count (mismatch_count),
        .error_count    (error_count)
    );

    assign model_word = imem[model_pc[9:2]];

    // opcode in the top byte, then three byte-wide fields
    function automatic logic [31:0] make_word(input logic [7:0] opc, input logic [7:0] f2,
                                              input logic [7:0] f1, input logic [7:0] f0);
        return {opc, f2, f1, f0};
    endfunction

    function automatic logic [31:0] read_word(input core_pkg::addr_t addr);
        if ($isunknown(addr))
            return 32'hFF00_0000;
        if (addr < MEM_WORDS * 4)
            return imem[addr[9:2]];
        return {8'hFF, addr[31:8] ^ addr[23:0]};    // opcode FF is a no-op
    endfunction

    task automatic emit(input logic [31:0] word, input bit runs);
        imem[prog_len] = word;
        prog_len++;
        if (runs)
            exec_total++;
    endtask

    // instruction memory with one cycle of latency
    always @(posedge CLK)
    begin
        instruction <= read_word(fetch_addr);
    end

    task automatic build_program();
        logic [7:0] opc;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            imem[i] = {8'hF0, 8'(i), 8'(~i), 8'(i * 37)};    // unused opcode F0
        end
        prog_len   = 0;
        exec_total = 0;
        for (int r = 0; r < 8; r++)
        begin
            emit(make_word(isa_pkg::OPC_MOV, 8'(r), 8'd0, 8'(r)), 1'b1);    // reads zero
        end
        emit(make_word(isa_pkg::OPC_LOADI, 8'd1, 8'd0, 8'h5a), 1'b1);
        emit(make_word(isa_pkg::OPC_LOADI, 8'd2, 8'd0, 8'h5a), 1'b1);
        emit(make_word(isa_pkg::OPC_MOV, 8'd3, 8'd0, 8'd1), 1'b1);
        emit(make_word(isa_pkg::OPC_LOADI, 8'd4, 8'd0, 8'hc3), 1'b1);
        emit(make_word(isa_pkg::OPC_BEQ, 8'd1, 8'd1, 8'd2), 1'b1);      // taken
        emit(make_word(isa_pkg::OPC_LOADI, 8'd5, 8'd0, 8'hee), 1'b0);
        emit(make_word(isa_pkg::OPC_BNE, 8'd3, 8'd1, 8'd2), 1'b1);      // falls through
        emit(make_word(isa_pkg::OPC_BNE, 8'd1, 8'd1, 8'd4), 1'b1);      // taken
        emit(make_word(isa_pkg::OPC_LOADI, 8'd6, 8'd0, 8'h77), 1'b0);
        emit(make_word(isa_pkg::OPC_BEQ, 8'd3, 8'd1, 8'd4), 1'b1);      // falls through
        // forward over one word, then back into it, then out
        emit(make_word(isa_pkg::OPC_J, 8'd1, 8'd0, 8'd0), 1'b1);
        emit(make_word(isa_pkg::OPC_J, 8'd1, 8'd0, 8'd0), 1'b1);
        emit(make_word(isa_pkg::OPC_J, 8'hfe, 8'd0, 8'd0), 1'b1);
        emit(make_word(8'd9, 8'd7, 8'd7, 8'd7), 1'b1);                  // unused opcode
        for (int r = 0; r < 8; r++)
        begin
            emit(make_word(isa_pkg::OPC_LOADI, 8'(r), 8'd0, 8'($urandom)), 1'b1);
        end
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            opc = 8'($urandom_range(isa_pkg::OPC_LOADI, isa_pkg::OPC_OR));
            emit(make_word(opc, 8'($urandom_range(0, 7)), 8'($urandom_range(0, 7)),
                           (opc == isa_pkg::OPC_LOADI) ? 8'($urandom)
                                                       : 8'($urandom_range(0, 7))), 1'b1);
        end
        emit(make_word(isa_pkg::OPC_J, 8'hff, 8'd0, 8'd0), 1'b1);      // jump to itself
    endtask

    initial
    begin
        int cycles;
        void'($urandom(SEED));
        timeouts = 0;
        build_program();
        cycles = 0;
        while (RESET !== 1'b0 && cycles < TIMEOUT)
        begin
            @(posedge CLK);
            cycles++;
        end
        if (RESET !== 1'b0)
        begin
            $display("reset was never released");
            timeouts++;
        end
        cycles = 0;
        while (timeouts == 0 && retire_count < exec_total + 4 && cycles < TIMEOUT)
        begin
            @(posedge CLK);
            cycles++;
        end
        if (timeouts == 0 && retire_count < exec_total + 4)
        begin
            $display("core stopped retiring after %0d instructions", retire_count);
            timeouts++;
        end
        @(negedge CLK);
        $display("retired %0d, mismatches %0d, other errors %0d, timeouts %0d",
                 retire_count, mismatch_count, error_count, timeouts);
        if (mismatch_count == 0 && error_count == 0 && timeouts == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
    output logic CLK,
    output logic RESET
);

    localparam real HALF_PERIOD  = 4.0;    // 8 ns clock
    localparam int  RESET_CYCLES = 3;

    initial
    begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

    initial
    begin
        RESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        RESET <= 1'b0;    // released on an edge like any other input
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/isa_pkg.sv
hw/core_pkg.sv
hw/ctrl_if.sv
hw/control_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/fetch_unit.sv
hw/cpu_core.sv
tests/tb_clock_gen.sv
tests/cpu_checker.sv
tests/cpu_tb.sv
